// ==== filelist.f ====
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_fwd_id.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
tests/rv_tb_clk.sv
tests/rv_core_assert.sv
tests/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

# 0 is SRAM, 1 is BRAM
for mt in 0 1; do
  verilator --binary --timing --assert -f filelist.f --top-module rv_core_tb \
    -Gmem_type=$mt -Mdir obj_$mt -o sim
  ./obj_$mt/sim | tee sim_$mt.log
  if grep -q "Done: errors found" sim_$mt.log; then
    exit 1
  fi
done

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb #(
  parameter int mem_type = rv_pkg::MEM_TYPE_SRAM
);
  import rv_pkg::*;

  localparam int SEND_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 400;

  logic clk, rst_n, in_valid, in_ready, out_valid, out_ready, bp_en;
  logic [XLEN-1:0] in_instr, out_data;
  logic [REG_W-1:0] out_rd;
  logic [31:0] rng_state;
  logic [XLEN-1:0] mregs [32];
  logic [XLEN-1:0] mmem [DMEM_WORDS];
  logic [REG_W-1:0] exp_rd_q [$];
  logic [XLEN-1:0] exp_data_q [$];

  rv_tb_clk clk_i (.clk(clk));

  rv_core #(
    .mem_type(mem_type)
  ) dut_i (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
    .in_instr(in_instr), .out_valid(out_valid), .out_ready(out_ready),
    .out_rd(out_rd), .out_data(out_data)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  // ISA reference model that runs at acceptance and queues the expected record
  task automatic model_exec(input logic [31:0] ins);
    logic [XLEN-1:0] a, b, res, ii, is, addr;
    a = mregs[ins[19:15]];
    b = mregs[ins[24:20]];
    ii = {{20{ins[31]}}, ins[31:20]};
    is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    res = '0;
    case (ins[6:0])
      OPC_OP: begin
        case (ins[14:12])
          3'b100: res = a ^ b;
          3'b110: res = a | b;
          3'b111: res = a & b;
          default: res = ins[30] ? a - b : a + b;
        endcase
      end
      OPC_OP_IMM: begin
        case (ins[14:12])
          3'b100: res = a ^ ii;
          3'b110: res = a | ii;
          3'b111: res = a & ii;
          default: res = a + ii;
        endcase
      end
      OPC_LUI: res = {ins[31:12], 12'b0};
      OPC_LOAD: begin
        addr = a + ii;
        res = mmem[addr[7:2]];
      end
      default: begin
        addr = a + is;
        mmem[addr[7:2]] = b;
      end
    endcase
    if (ins[6:0] == OPC_STORE) begin
      exp_rd_q.push_back('0);
      exp_data_q.push_back(b);
    end else begin
      exp_rd_q.push_back(ins[11:7]);
      exp_data_q.push_back(res);
      if (ins[11:7] != '0) mregs[ins[11:7]] = res;
    end
  endtask

  task automatic check_retire();
    logic [REG_W-1:0] e_rd;
    logic [XLEN-1:0] e_data;
    if (exp_rd_q.size() == 0) begin
      abort_run("Retire record seen with no instruction outstanding");
    end else begin
      e_rd = exp_rd_q.pop_front();
      e_data = exp_data_q.pop_front();
      if (out_rd !== e_rd || out_data !== e_data) begin
        abort_run($sformatf("CHECK FAILED at %0t: retire rd %0d data %h, expected rd %0d data %h",
                            $time, out_rd, out_data, e_rd, e_data));
      end
    end
  endtask

  // One cycle that drives on the falling edge and samples once inputs settle
  task automatic tick(input logic send, input logic [31:0] ins, output logic taken);
    logic [31:0] r;
    @(negedge clk);
    r = next_rand();
    out_ready = bp_en ? (r[1:0] != 2'b00) : 1'b1;
    in_valid = send;
    in_instr = send ? ins : '0;
    #1;
    if (out_valid && out_ready) check_retire();
    taken = send && in_ready;
    if (taken) model_exec(ins);
  endtask

  task automatic send_instr(input logic [31:0] ins);
    logic taken;
    int count;
    count = 0;
    taken = 1'b0;
    while (!taken) begin
      tick(1'b1, ins, taken);
      count++;
      if (!taken && count > SEND_TIMEOUT) abort_run("Timed out waiting for in_ready");
    end
  endtask

  task automatic drain();
    logic taken;
    int count;
    count = 0;
    while (exp_rd_q.size() != 0) begin
      tick(1'b0, '0, taken);
      count++;
      if (count > DRAIN_TIMEOUT) abort_run("Timed out waiting for outstanding retires");
    end
  endtask

  function automatic logic [31:0] rand_instr();
    logic [31:0] r;
    logic [4:0] rd, rs1, rs2;
    r = next_rand();
    rd = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    case (r[12:9])
      4'd0: return enc_r(7'h20, rs2, rs1, 3'b000, rd);
      4'd1: return enc_r(7'h00, rs2, rs1, 3'b100, rd);
      4'd2: return enc_r(7'h00, rs2, rs1, 3'b110, rd);
      4'd3: return enc_r(7'h00, rs2, rs1, 3'b111, rd);
      4'd4: return enc_i(r[24:13], rs1, 3'b000, rd, OPC_OP_IMM);
      4'd5: return enc_i(r[24:13], rs1, 3'b100, rd, OPC_OP_IMM);
      4'd6: return enc_u(r[31:12], rd);
      4'd7, 4'd8: return enc_i({4'b0, r[18:13], 2'b00}, 5'd0, 3'b010, rd, OPC_LOAD);
      4'd9, 4'd10: return enc_s({4'b0, r[18:13], 2'b00}, rs2, 5'd0);
      default: return enc_r(7'h00, rs2, rs1, 3'b000, rd);
    endcase
  endfunction

  initial begin
    rng_state = 32'he779_784a;
    bp_en = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    out_ready = 1'b0;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Fill every data word so that no load returns an unknown value
    for (int a = 0; a < DMEM_WORDS; a++) begin
      send_instr(enc_i({6'(a), ~6'(a)}, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
      send_instr(enc_s({4'b0, 6'(a), 2'b00}, 5'd5, 5'd0));
    end

    // Dependences at distance 1, 2 and 3
    send_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    send_instr(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    send_instr(enc_i(12'd9, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    send_instr(enc_i(12'd1, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
    send_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd2));
    send_instr(enc_i(12'hff3, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    send_instr(enc_i(12'd2, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
    send_instr(enc_i(12'd3, 5'd0, 3'b000, 5'd6, OPC_OP_IMM));
    send_instr(enc_r(7'h00, 5'd4, 5'd1, 3'b100, 5'd2));

    // Load then consumer, directly and one instruction later
    send_instr(enc_i(12'd8, 5'd0, 3'b010, 5'd7, OPC_LOAD));
    send_instr(enc_r(7'h00, 5'd7, 5'd7, 3'b000, 5'd8));
    send_instr(enc_i(12'd12, 5'd0, 3'b010, 5'd9, OPC_LOAD));
    send_instr(enc_i(12'd1, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
    send_instr(enc_r(7'h00, 5'd8, 5'd9, 3'b110, 5'd11));

    // Stores followed by loads of the same and other words
    send_instr(enc_i(12'h05a, 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
    send_instr(enc_s(12'd16, 5'd12, 5'd0));
    send_instr(enc_i(12'd16, 5'd0, 3'b010, 5'd13, OPC_LOAD));
    send_instr(enc_i(12'd20, 5'd0, 3'b010, 5'd14, OPC_LOAD));
    send_instr(enc_u(20'habcde, 5'd15));
    send_instr(enc_s(12'd20, 5'd15, 5'd0));
    send_instr(enc_i(12'd20, 5'd0, 3'b010, 5'd16, OPC_LOAD));

    // Writes to x0 retire but never forward
    send_instr(enc_i(12'h123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
    send_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd17));
    send_instr(enc_u(20'h12345, 5'd0));
    send_instr(enc_r(7'h00, 5'd12, 5'd0, 3'b110, 5'd18));
    drain();

    // Random program under random out_ready gaps
    bp_en = 1'b1;
    for (int n = 0; n < 200; n++) send_instr(rand_instr());
    drain();

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tests/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     in_valid,
  input logic                     in_ready,
  input logic                     out_valid,
  input logic                     out_ready,
  input logic [rv_pkg::REG_W-1:0] out_rd,
  input logic [ rv_pkg::XLEN-1:0] out_data
);

  // Retire record holds while the receiver is not ready
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_rd) && $stable(out_data))
    else $error("retire record changed while out_ready was low");

  // No instruction is taken while a retire record waits
  a_in_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && out_valid && !out_ready |-> !in_ready)
    else $error("instruction accepted while the retire stream was stalled");

  // First cycle out of reset accepts and retires nothing
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !out_valid && !in_ready)
    else $error("stream handshake active in the first cycle after reset");

  a_data_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_data) && !$isunknown(out_rd))
    else $error("retire record is unknown while out_valid is high");

endmodule

bind rv_core rv_core_assert assert_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .in_ready (in_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_rd   (out_rd),
  .out_data (out_data)
);

// ==== tests/rv_tb_clk.sv ====
`timescale 1ns/1ps

module rv_tb_clk (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter int mem_type = rv_pkg::MEM_TYPE_SRAM
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [ rv_pkg::XLEN-1:0] in_instr,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [rv_pkg::REG_W-1:0] out_rd,
  output logic [ rv_pkg::XLEN-1:0] out_data
);
  import rv_pkg::*;

  logic adv;
  logic valid_ex, reg_write_out_ex, reg_write_ex;
  alu_op_e alu_op_ex;
  logic [XLEN-1:0] op_a_ex, op_b_ex, store_data_ex;
  logic [REG_W-1:0] rd_out_ex, rd_ex;
  res_src_e res_src_ex, res_src_mem;
  logic valid_mem, reg_write_mem, reg_write_wb;
  logic [REG_W-1:0] rd_mem, rd_wb;
  logic [XLEN-1:0] result_mem, store_data_mem, load_data_mem, rd_data_wb;

  // Whole pipeline freezes while a retire record waits
  assign adv = !(out_valid && !out_ready);

  rv_decode #(
    .mem_type(mem_type)
  ) decode_i (
    .clk(clk), .rst_n(rst_n), .adv(adv),
    .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
    .rd_ex(rd_ex), .reg_write_ex(reg_write_ex),
    .rd_mem(rd_mem), .reg_write_mem(reg_write_mem), .res_src_mem(res_src_mem),
    .result_mem(result_mem), .load_data_mem(load_data_mem),
    .rd_wb(rd_wb), .reg_write_wb(reg_write_wb), .rd_data_wb(rd_data_wb),
    .valid_ex(valid_ex), .alu_op_ex(alu_op_ex), .op_a_ex(op_a_ex), .op_b_ex(op_b_ex),
    .store_data_ex(store_data_ex), .rd_out_ex(rd_out_ex),
    .reg_write_out_ex(reg_write_out_ex), .res_src_ex(res_src_ex)
  );

  rv_execute execute_i (
    .clk(clk), .rst_n(rst_n), .adv(adv),
    .valid_ex(valid_ex), .alu_op_ex(alu_op_ex), .op_a_ex(op_a_ex), .op_b_ex(op_b_ex),
    .store_data_ex(store_data_ex), .rd_out_ex(rd_out_ex),
    .reg_write_out_ex(reg_write_out_ex), .res_src_ex(res_src_ex),
    .rd_ex(rd_ex), .reg_write_ex(reg_write_ex),
    .valid_mem(valid_mem), .rd_mem(rd_mem), .reg_write_mem(reg_write_mem),
    .res_src_mem(res_src_mem), .result_mem(result_mem), .store_data_mem(store_data_mem)
  );

  rv_result #(
    .mem_type(mem_type)
  ) result_i (
    .clk(clk), .rst_n(rst_n), .adv(adv),
    .valid_mem(valid_mem), .rd_mem(rd_mem), .reg_write_mem(reg_write_mem),
    .res_src_mem(res_src_mem), .result_mem(result_mem), .store_data_mem(store_data_mem),
    .load_data_mem(load_data_mem),
    .rd_wb(rd_wb), .reg_write_wb(reg_write_wb), .rd_data_wb(rd_data_wb),
    .out_valid(out_valid), .out_rd(out_rd), .out_data(out_data)
  );

endmodule

// ==== design/rv_result.sv ====
`timescale 1ns/1ps

module rv_result #(
  parameter int mem_type = rv_pkg::MEM_TYPE_SRAM
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     adv,
  input  logic                     valid_mem,
  input  logic [rv_pkg::REG_W-1:0] rd_mem,
  input  logic                     reg_write_mem,
  input  rv_pkg::res_src_e         res_src_mem,
  input  logic [ rv_pkg::XLEN-1:0] result_mem,
  input  logic [ rv_pkg::XLEN-1:0] store_data_mem,
  output logic [ rv_pkg::XLEN-1:0] load_data_mem,
  output logic [rv_pkg::REG_W-1:0] rd_wb,
  output logic                     reg_write_wb,
  output logic [ rv_pkg::XLEN-1:0] rd_data_wb,
  output logic                     out_valid,
  output logic [rv_pkg::REG_W-1:0] out_rd,
  output logic [ rv_pkg::XLEN-1:0] out_data
);
  import rv_pkg::*;

  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] addr;
  logic [XLEN-1:0] mem_value, data_wb;
  logic valid_wb;
  res_src_e res_src_wb;

  assign addr = result_mem[DMEM_AW+1:2];

  // Store commits as it leaves MEM
  always_ff @(posedge clk) begin
    if (adv && valid_mem && res_src_mem == RES_NONE) dmem[addr] <= store_data_mem;
  end

  if (mem_type == MEM_TYPE_SRAM) begin : g_sram
    assign load_data_mem = dmem[addr];
    assign rd_data_wb = data_wb;
  end else begin : g_bram
    logic [XLEN-1:0] bram_q;

    // Registered read lands together with the load in WB
    always_ff @(posedge clk) begin
      if (adv) bram_q <= dmem[addr];
    end

    assign load_data_mem = '0;
    assign rd_data_wb = (res_src_wb == RES_MEM) ? bram_q : data_wb;
  end

  always_comb begin
    case (res_src_mem)
      RES_MEM: mem_value = load_data_mem;
      RES_NONE: mem_value = store_data_mem;
      default: mem_value = result_mem;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_wb <= 1'b0;
      rd_wb <= '0;
      reg_write_wb <= 1'b0;
      res_src_wb <= RES_ALU;
      data_wb <= '0;
    end else if (adv) begin
      valid_wb <= valid_mem;
      rd_wb <= rd_mem;
      reg_write_wb <= reg_write_mem;
      res_src_wb <= res_src_mem;
      data_wb <= mem_value;
    end
  end

  // Retire record comes straight from MEM/WB
  assign out_valid = valid_wb;
  assign out_rd = rd_wb;
  assign out_data = rd_data_wb;

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     adv,
  input  logic                     valid_ex,
  input  rv_pkg::alu_op_e          alu_op_ex,
  input  logic [ rv_pkg::XLEN-1:0] op_a_ex,
  input  logic [ rv_pkg::XLEN-1:0] op_b_ex,
  input  logic [ rv_pkg::XLEN-1:0] store_data_ex,
  input  logic [rv_pkg::REG_W-1:0] rd_out_ex,
  input  logic                     reg_write_out_ex,
  input  rv_pkg::res_src_e         res_src_ex,
  output logic [rv_pkg::REG_W-1:0] rd_ex,
  output logic                     reg_write_ex,
  output logic                     valid_mem,
  output logic [rv_pkg::REG_W-1:0] rd_mem,
  output logic                     reg_write_mem,
  output rv_pkg::res_src_e         res_src_mem,
  output logic [ rv_pkg::XLEN-1:0] result_mem,
  output logic [ rv_pkg::XLEN-1:0] store_data_mem
);
  import rv_pkg::*;

  logic [XLEN-1:0] alu_out;

  // Loads and stores use the add result as the address
  always_comb begin
    case (alu_op_ex)
      ALU_SUB: alu_out = op_a_ex - op_b_ex;
      ALU_AND: alu_out = op_a_ex & op_b_ex;
      ALU_OR: alu_out = op_a_ex | op_b_ex;
      ALU_XOR: alu_out = op_a_ex ^ op_b_ex;
      ALU_PASS_B: alu_out = op_b_ex;
      default: alu_out = op_a_ex + op_b_ex;
    endcase
  end

  // Hazard source for the decode stall
  assign rd_ex = rd_out_ex;
  assign reg_write_ex = valid_ex && reg_write_out_ex;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_mem <= 1'b0;
      rd_mem <= '0;
      reg_write_mem <= 1'b0;
      res_src_mem <= RES_ALU;
      result_mem <= '0;
      store_data_mem <= '0;
    end else if (adv) begin
      valid_mem <= valid_ex;
      rd_mem <= rd_out_ex;
      reg_write_mem <= reg_write_ex;
      res_src_mem <= res_src_ex;
      result_mem <= alu_out;
      store_data_mem <= store_data_ex;
    end
  end

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode #(
  parameter int mem_type = rv_pkg::MEM_TYPE_SRAM
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     adv,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  logic [ rv_pkg::XLEN-1:0] in_instr,
  input  logic [rv_pkg::REG_W-1:0] rd_ex,
  input  logic                     reg_write_ex,
  input  logic [rv_pkg::REG_W-1:0] rd_mem,
  input  logic                     reg_write_mem,
  input  rv_pkg::res_src_e         res_src_mem,
  input  logic [ rv_pkg::XLEN-1:0] result_mem,
  input  logic [ rv_pkg::XLEN-1:0] load_data_mem,
  input  logic [rv_pkg::REG_W-1:0] rd_wb,
  input  logic                     reg_write_wb,
  input  logic [ rv_pkg::XLEN-1:0] rd_data_wb,
  output logic                     valid_ex,
  output rv_pkg::alu_op_e          alu_op_ex,
  output logic [ rv_pkg::XLEN-1:0] op_a_ex,
  output logic [ rv_pkg::XLEN-1:0] op_b_ex,
  output logic [ rv_pkg::XLEN-1:0] store_data_ex,
  output logic [rv_pkg::REG_W-1:0] rd_out_ex,
  output logic                     reg_write_out_ex,
  output rv_pkg::res_src_e         res_src_ex
);
  import rv_pkg::*;

  logic run_q, id_valid, id_go, stall, ex_hit, load_hit;
  logic [XLEN-1:0] id_instr;
  logic [6:0] opcode;
  logic [REG_W-1:0] rs1, rs2, dec_rd;
  logic [XLEN-1:0] imm_i, imm_s, imm_u, dec_imm;
  logic [XLEN-1:0] rs1_data, rs2_data, fwd_rs1, fwd_rs2;
  logic use_rs1, use_rs2, dec_b_reg, dec_reg_write;
  alu_op_e dec_alu_op;
  res_src_e dec_res_src;

  // Holds in_ready low for the first cycle out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) run_q <= 1'b0;
    else run_q <= 1'b1;
  end

  assign in_ready = run_q && adv && !stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
      id_instr <= '0;
    end else if (in_ready) begin
      id_valid <= in_valid;
      if (in_valid) id_instr <= in_instr;
    end
  end

  assign opcode = id_instr[6:0];
  assign rs1 = id_instr[19:15];
  assign rs2 = id_instr[24:20];
  assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_s = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
  assign imm_u = {id_instr[31:12], 12'b0};

  always_comb begin
    dec_alu_op = ALU_ADD;
    dec_res_src = RES_ALU;
    dec_reg_write = 1'b1;
    dec_rd = id_instr[11:7];
    dec_imm = imm_i;
    dec_b_reg = 1'b0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        case (id_instr[14:12])
          3'b100: dec_alu_op = ALU_XOR;
          3'b110: dec_alu_op = ALU_OR;
          3'b111: dec_alu_op = ALU_AND;
          default: dec_alu_op = ALU_ADD;
        endcase
        if (opcode == OPC_OP) begin
          dec_b_reg = 1'b1;
          use_rs2 = 1'b1;
          if (id_instr[14:12] == 3'b000 && id_instr[30]) dec_alu_op = ALU_SUB;
        end
      end
      OPC_LUI: begin
        dec_alu_op = ALU_PASS_B;
        dec_imm = imm_u;
        use_rs1 = 1'b0;
      end
      OPC_LOAD: dec_res_src = RES_MEM;
      OPC_STORE: begin
        // Store retires with rd zero and the stored word
        dec_res_src = RES_NONE;
        dec_reg_write = 1'b0;
        dec_rd = '0;
        dec_imm = imm_s;
        use_rs2 = 1'b1;
      end
      default: begin
        // Unsupported words retire as a harmless zero record
        dec_alu_op = ALU_PASS_B;
        dec_reg_write = 1'b0;
        dec_rd = '0;
        dec_imm = '0;
        use_rs1 = 1'b0;
      end
    endcase
  end

  rv_regfile regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1),
    .rs2_addr(rs2),
    .rd_addr (rd_wb),
    .wr_en   (reg_write_wb && adv),
    .wr_data (rd_data_wb),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  rv_fwd_id #(
    .mem_type(mem_type)
  ) fwd_i (
    .rs1_id       (rs1),
    .rs2_id       (rs2),
    .rs1_data_id  (rs1_data),
    .rs2_data_id  (rs2_data),
    .rd_mem       (rd_mem),
    .reg_write_mem(reg_write_mem),
    .res_src_mem  (res_src_mem),
    .result_mem   (result_mem),
    .load_data_mem(load_data_mem),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb),
    .rd_data_wb   (rd_data_wb),
    .fwd_rs1_id   (fwd_rs1),
    .fwd_rs2_id   (fwd_rs2)
  );

  // EX result is not ready yet, nor is a BRAM load in MEM
  assign ex_hit = reg_write_ex && rd_ex != '0 &&
                  ((use_rs1 && rd_ex == rs1) || (use_rs2 && rd_ex == rs2));
  assign load_hit = (mem_type == MEM_TYPE_BRAM) && reg_write_mem &&
                    res_src_mem == RES_MEM && rd_mem != '0 &&
                    ((use_rs1 && rd_mem == rs1) || (use_rs2 && rd_mem == rs2));
  assign stall = id_valid && (ex_hit || load_hit);
  assign id_go = id_valid && !stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_ex <= 1'b0;
      alu_op_ex <= ALU_ADD;
      op_a_ex <= '0;
      op_b_ex <= '0;
      store_data_ex <= '0;
      rd_out_ex <= '0;
      reg_write_out_ex <= 1'b0;
      res_src_ex <= RES_ALU;
    end else if (adv) begin
      valid_ex <= id_go;
      alu_op_ex <= dec_alu_op;
      op_a_ex <= fwd_rs1;
      op_b_ex <= dec_b_reg ? fwd_rs2 : dec_imm;
      store_data_ex <= fwd_rs2;
      rd_out_ex <= dec_rd;
      reg_write_out_ex <= id_go && dec_reg_write;
      res_src_ex <= dec_res_src;
    end
  end

endmodule

// ==== design/rv_fwd_id.sv ====
`timescale 1ns/1ps

module rv_fwd_id #(
  parameter int mem_type = rv_pkg::MEM_TYPE_SRAM
) (
  input  logic [rv_pkg::REG_W-1:0] rs1_id,
  input  logic [rv_pkg::REG_W-1:0] rs2_id,
  input  logic [ rv_pkg::XLEN-1:0] rs1_data_id,
  input  logic [ rv_pkg::XLEN-1:0] rs2_data_id,
  input  logic [rv_pkg::REG_W-1:0] rd_mem,
  input  logic                     reg_write_mem,
  input  rv_pkg::res_src_e         res_src_mem,
  input  logic [ rv_pkg::XLEN-1:0] result_mem,
  input  logic [ rv_pkg::XLEN-1:0] load_data_mem,
  input  logic [rv_pkg::REG_W-1:0] rd_wb,
  input  logic                     reg_write_wb,
  input  logic [ rv_pkg::XLEN-1:0] rd_data_wb,
  output logic [ rv_pkg::XLEN-1:0] fwd_rs1_id,
  output logic [ rv_pkg::XLEN-1:0] fwd_rs2_id
);
  import rv_pkg::*;

  logic is_load_mem;
  logic mem_rs1, mem_rs2;
  logic wb_rs1, wb_rs2;

  // A source matches only when it writes a nonzero register
  function automatic logic hit(input logic [REG_W-1:0] src, input logic [REG_W-1:0] dst,
                               input logic we);
    return we && dst != '0 && dst == src;
  endfunction

  assign is_load_mem = (res_src_mem == RES_MEM);

  // MEM results other than loads are ready for either memory kind
  assign mem_rs1 = hit(rs1_id, rd_mem, reg_write_mem && !is_load_mem);
  assign mem_rs2 = hit(rs2_id, rd_mem, reg_write_mem && !is_load_mem);

  assign wb_rs1 = hit(rs1_id, rd_wb, reg_write_wb);
  assign wb_rs2 = hit(rs2_id, rd_wb, reg_write_wb);

  if (mem_type == MEM_TYPE_SRAM) begin : g_sram
    logic ld_rs1, ld_rs2;

    // Asynchronous SRAM read gives load data while still in MEM
    assign ld_rs1 = hit(rs1_id, rd_mem, reg_write_mem && is_load_mem);
    assign ld_rs2 = hit(rs2_id, rd_mem, reg_write_mem && is_load_mem);

    always_comb begin
      if (ld_rs1) fwd_rs1_id = load_data_mem;
      else if (mem_rs1) fwd_rs1_id = result_mem;
      else if (wb_rs1) fwd_rs1_id = rd_data_wb;
      else fwd_rs1_id = rs1_data_id;
    end

    always_comb begin
      if (ld_rs2) fwd_rs2_id = load_data_mem;
      else if (mem_rs2) fwd_rs2_id = result_mem;
      else if (wb_rs2) fwd_rs2_id = rd_data_wb;
      else fwd_rs2_id = rs2_data_id;
    end
  end else begin : g_bram
    // Load data in MEM is not ready yet and decode stalls until it reaches WB
    always_comb begin
      if (mem_rs1) fwd_rs1_id = result_mem;
      else if (wb_rs1) fwd_rs1_id = rd_data_wb;
      else fwd_rs1_id = rs1_data_id;
    end

    always_comb begin
      if (mem_rs2) fwd_rs2_id = result_mem;
      else if (wb_rs2) fwd_rs2_id = rd_data_wb;
      else fwd_rs2_id = rs2_data_id;
    end
  end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [rv_pkg::REG_W-1:0] rs1_addr,
  input  logic [rv_pkg::REG_W-1:0] rs2_addr,
  input  logic [rv_pkg::REG_W-1:0] rd_addr,
  input  logic                     wr_en,
  input  logic [ rv_pkg::XLEN-1:0] wr_data,
  output logic [ rv_pkg::XLEN-1:0] rs1_data,
  output logic [ rv_pkg::XLEN-1:0] rs2_data
);
  import rv_pkg::*;

  // No storage for x0
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && rd_addr != '0) begin
      regs[rd_addr] <= wr_data;
    end
  end

  // Same-cycle writes reach ID through WB forwarding
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

  // Datapath widths
  localparam int XLEN = 32;
  localparam int REG_W = 5;

  // Data memory geometry, word addressed
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW = $clog2(DMEM_WORDS);

  // Values of the mem_type parameter
  localparam int MEM_TYPE_SRAM = 0;
  localparam int MEM_TYPE_BRAM = 1;

  // Major opcodes
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // RES_NONE marks stores, which write no register
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_NONE
  } res_src_e;

endpackage
